/* cpuTop.f */
+incdir+sim
hw/cpuPkg.sv
hw/cpuAlu.sv
hw/cpuDatapath.sv
hw/cpuSequencer.sv
hw/cpuTop.sv
sim/cpuTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpuTb -f cpuTop.f -o cpuTb
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

output=$(./obj_dir/cpuTb 2>&1)
runStatus=$?
printf '%s\n' "$output"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

# Pass only when the pass line is in the output
if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* sim/cpuTbModel.svh */
`ifndef cpuTbModelSvh
`define cpuTbModelSvh

////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////

// 16-bit Galois LFSR state
logic [15:0] lfsrState;

// One right shift, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] nextLfsr(input logic [15:0] state);
    logic [15:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
        shifted = shifted ^ 16'hB400;
    end
    return shifted;
endfunction

// One LFSR step per bit, bits enter from the right
function automatic byte_t takeBits(input int count);
    byte_t value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        lfsrState = nextLfsr(lfsrState);
        value = {value[6:0], lfsrState[0]};
    end
    return value;
endfunction

////////////////////////////////////////////////////////////
// Instruction-level reference model
////////////////////////////////////////////////////////////

// Registers and memory persist from one thread to the next
byte_t modelA;
byte_t modelB;
byte_t modelRam [256];

// ALU behaviour, 8-bit wrap on every result
function automatic byte_t aluRef(input aluOp_t op, input byte_t a, input byte_t b);
    case (op)
        add:         return a + b;
        sub:         return a - b;
        // Low byte of the product
        mul:         return a * b;
        shiftLeftA:  return a << 1;
        shiftRightA: return a >> 1;
        incA:        return a + 8'd1;
        incB:        return b + 8'd1;
        decA:        return a - 8'd1;
        decB:        return b - 8'd1;
        cmpEq:       return (a == b) ? 8'd1 : 8'd0;
        cmpGt:       return (a > b) ? 8'd1 : 8'd0;
        cmpLt:       return (a < b) ? 8'd1 : 8'd0;
        default:     return a;
    endcase
endfunction

// Runs one thread from its start address up to gotoIdle
// Every store lands in the expected write queues
task automatic runThread(input byte_t start);
    byte_t  pc;
    byte_t  operand;
    instr_t op;
    logic   done;
    pc   = start;
    done = 1'b0;
    while (!done) begin
        op      = instr_t'(rom[pc]);
        // Second byte, only meaningful for two-byte classes
        operand = rom[pc + 8'd1];
        case (op.opClass)
            loadA: begin
                modelA = modelRam[operand];
                pc     = pc + 8'd2;
            end
            loadB: begin
                modelB = modelRam[operand];
                pc     = pc + 8'd2;
            end
            storeA: begin
                expAddr.push_back(operand);
                expData.push_back(modelA);
                modelRam[operand] = modelA;
                pc = pc + 8'd2;
            end
            storeB: begin
                expAddr.push_back(operand);
                expData.push_back(modelB);
                modelRam[operand] = modelB;
                pc = pc + 8'd2;
            end
            mathsA: begin
                modelA = aluRef(op.aluOp, modelA, modelB);
                pc     = pc + 8'd1;
            end
            mathsB: begin
                modelB = aluRef(op.aluOp, modelA, modelB);
                pc     = pc + 8'd1;
            end
            // Taken only on a result of exactly 1
            branch: begin
                if (aluRef(op.aluOp, modelA, modelB) == 8'd1) begin
                    pc = operand;
                end else begin
                    pc = pc + 8'd2;
                end
            end
            gotoAddr: pc = operand;
            gotoIdle: done = 1'b1;
            default: begin
                done = 1'b1;
                reportError("model reached an unknown opcode");
            end
        endcase
    end
endtask

`endif

/* sim/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
    import cpuPkg::*;

    ////////////////////////////////////////////////////////////
    // DUT ports and memories
    ////////////////////////////////////////////////////////////

    logic       CLK = 1'b0;
    logic       RESET;
    logic [1:0] irqRaise;
    romWord_t   romData;
    byte_t      busRdData = '0;
    byte_t      romAddr;
    busReq_t    busReq;
    logic [1:0] irqAck;

    // Program ROM and data RAM images
    byte_t rom [256];
    byte_t ram [256];
    // First register stage of the RAM read
    byte_t memAddr = '0;

    // Expected writes in program order consumed by index
    byte_t expAddr [$];
    byte_t expData [$];
    int    writesSeen = 0;
    logic  weLast = 1'b0;
    // High while an acknowledge may legally appear
    logic  ackWindow = 1'b0;

    // Program under construction
    opClass_t progClass [32];
    byte_t    progStart [32];

    `include "cpuTbModel.svh"

    // 40 ns period
    always #20 CLK = ~CLK;

    cpuTop cpuTop_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .romData   (romData),
        .busRdData (busRdData),
        .irqRaise  (irqRaise),
        .romAddr   (romAddr),
        .busReq    (busReq),
        .irqAck    (irqAck)
    );

    // Zero-latency ROM
    assign romData = romWord_t'(rom[romAddr]);

    // Odd multiplier keeps every address bit in the value
    function automatic byte_t fillValue(input byte_t a);
        return (a * 8'd29) + 8'd7;
    endfunction

    // RAM registers the address and then the data
    always @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < 256; i++) begin
                ram[i[7:0]] <= fillValue(i[7:0]);
            end
        end else if (busReq.we) begin
            ram[busReq.addr] <= busReq.wrData;
        end
        memAddr   <= busReq.addr;
        busRdData <= ram[memAddr];
    end

    ////////////////////////////////////////////////////////////
    // Error reporting
    ////////////////////////////////////////////////////////////

    task automatic stopRun();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic reportError(input string why);
        $display("error at %0t ns: %s", $time, why);
        stopRun();
    endtask

    task automatic reportMismatch(input string name, input int got, input int exp);
        $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        stopRun();
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////////////////////////

    // Sampled mid-cycle away from the DUT's clock edge
    always @(negedge CLK) begin
        if (!RESET) begin
            if (busReq.we) begin
                assert (!weLast) else reportError("busReq.we high for two cycles");
                assert (writesSeen < expAddr.size())
                    else reportError("write seen with none expected");
                assert (busReq.addr == expAddr[writesSeen])
                    else reportMismatch("busReq.addr", int'(busReq.addr),
                                        int'(expAddr[writesSeen]));
                assert (busReq.wrData == expData[writesSeen])
                    else reportMismatch("busReq.wrData", int'(busReq.wrData),
                                        int'(expData[writesSeen]));
                writesSeen = writesSeen + 1;
            end
            weLast = busReq.we;
            if (!ackWindow) begin
                assert (irqAck == 2'b00)
                    else reportMismatch("irqAck", int'(irqAck), 0);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Program generation
    ////////////////////////////////////////////////////////////

    // Random program of count instructions ending in gotoIdle
    // Jumps only go forward to instruction starts
    task automatic buildProgram(input byte_t base, input int count);
        byte_t  pick;
        byte_t  at;
        aluOp_t op;
        int     next;
        int     target;
        progStart[0] = base;
        // First pass picks classes and start addresses
        for (int i = 0; i < count; i++) begin
            if (i == count - 1) begin
                progClass[i[4:0]] = gotoIdle;
            end else begin
                // Three bits cover loadA up to gotoAddr
                pick = takeBits(3);
                progClass[i[4:0]] = opClass_t'(pick[3:0]);
                next = i + 1;
                if (progClass[i[4:0]] == mathsA || progClass[i[4:0]] == mathsB) begin
                    progStart[next[4:0]] = progStart[i[4:0]] + 8'd1;
                end else begin
                    progStart[next[4:0]] = progStart[i[4:0]] + 8'd2;
                end
            end
        end
        // Second pass fills opcode and operand bytes
        for (int i = 0; i < count; i++) begin
            at = progStart[i[4:0]];
            op = add;
            if (progClass[i[4:0]] == mathsA || progClass[i[4:0]] == mathsB) begin
                pick = takeBits(4) % 8'd12;
                op   = aluOp_t'(pick[3:0]);
            end else if (progClass[i[4:0]] == branch) begin
                pick = takeBits(2);
                if (pick == 8'd0) begin
                    op = cmpEq;
                end else if (pick == 8'd1) begin
                    op = cmpGt;
                end else begin
                    op = cmpLt;
                end
            end
            rom[at] = {op, progClass[i[4:0]]};
            case (progClass[i[4:0]])
                // RAM operands stay in 0 to 31
                loadA, loadB, storeA, storeB: rom[at + 8'd1] = takeBits(5);
                branch, gotoAddr: begin
                    pick   = takeBits(4);
                    target = i + 1 + (int'(pick) % (count - 1 - i));
                    rom[at + 8'd1] = progStart[target[4:0]];
                end
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////

    // Quiet bus and no acknowledge while nothing is raised
    task automatic checkIdleOutputs(input int cycles);
        repeat (cycles) begin
            @(negedge CLK);
            assert (irqAck == 2'b00) else reportMismatch("irqAck", int'(irqAck), 0);
            assert (busReq.we == 1'b0) else reportMismatch("busReq.we", int'(busReq.we), 0);
            assert (busReq.addr == busIdleAddr)
                else reportMismatch("busReq.addr", int'(busReq.addr), int'(busIdleAddr));
        end
    endtask

    // Holds the lines until the DUT acknowledges from idle
    task automatic wakeThread(input logic [1:0] lines, input logic [1:0] expectAck,
                              input byte_t startAddr);
        int waited;
        waited    = 0;
        ackWindow = 1'b1;
        @(posedge CLK);
        irqRaise <= lines;
        @(negedge CLK);
        while (irqAck == 2'b00) begin
            waited = waited + 1;
            assert (waited < 400) else reportError("timed out waiting for irqAck");
            @(negedge CLK);
        end
        assert (irqAck == expectAck)
            else reportMismatch("irqAck", int'(irqAck), int'(expectAck));
        @(posedge CLK);
        irqRaise <= 2'b00;
        // Pulse must be gone one cycle later
        @(negedge CLK);
        assert (irqAck == 2'b00) else reportMismatch("irqAck", int'(irqAck), 0);
        ackWindow = 1'b0;
        // First decode four cycles after the wake-up fetches the thread start
        repeat (2) @(negedge CLK);
        assert (romAddr == startAddr)
            else reportMismatch("romAddr", int'(romAddr), int'(startAddr));
    endtask

    task automatic waitWritesDrained();
        int waited;
        waited = 0;
        while (writesSeen < expAddr.size()) begin
            waited = waited + 1;
            assert (waited < 1000) else reportError("timed out waiting for expected writes");
            @(negedge CLK);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        RESET    <= 1'b1;
        irqRaise <= 2'b00;
        lfsrState = 16'd16173;
        modelA    = '0;
        modelB    = '0;
        for (int i = 0; i < 256; i++) begin
            rom[i[7:0]]      = (i[7:0] * 8'd53) + 8'd91;
            modelRam[i[7:0]] = fillValue(i[7:0]);
        end
        buildProgram(8'h00, 20);
        buildProgram(8'h80, 20);
        rom[vecIrq0] = 8'h00;
        rom[vecIrq1] = 8'h80;

        repeat (10) @(posedge CLK);
        RESET <= 1'b0;

        checkIdleOutputs(16);

        // Both lines raised picks line 0 and line 1 follows alone
        for (int round = 0; round < 2; round++) begin
            runThread(rom[vecIrq0]);
            wakeThread(2'b11, 2'b01, rom[vecIrq0]);
            waitWritesDrained();
            runThread(rom[vecIrq1]);
            wakeThread(2'b10, 2'b10, rom[vecIrq1]);
            waitWritesDrained();
        end
        // One more wake-up shows the last thread went back to idle
        wakeThread(2'b01, 2'b01, rom[vecIrq0]);

        $display("checked %0d writes", writesSeen);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire cpuPkg::romWord_t romData,
    input  wire cpuPkg::byte_t    busRdData,
    input  wire [1:0]             irqRaise,
    output cpuPkg::byte_t         romAddr,
    output cpuPkg::busReq_t       busReq,
    output logic [1:0]            irqAck
);
    import cpuPkg::*;

    // Sequencer to datapath
    dpCtrl_t ctrl;

    // Compare result back for branches
    byte_t aluResult;

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////

    cpuSequencer sequencerInst (
        .CLK       (CLK),
        .RESET     (RESET),
        .romData   (romData),
        .aluResult (aluResult),
        .irqRaise  (irqRaise),
        .romAddr   (romAddr),
        .irqAck    (irqAck),
        .ctrl      (ctrl)
    );

    ////////////////////////////////////////////////////////////
    // Registers, ALU and bus
    ////////////////////////////////////////////////////////////

    cpuDatapath datapathInst (
        .CLK       (CLK),
        .RESET     (RESET),
        .romData   (romData),
        .busRdData (busRdData),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .busReq    (busReq)
    );

endmodule

`default_nettype wire

/* hw/cpuSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuSequencer (
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire cpuPkg::romWord_t romData,
    input  wire cpuPkg::byte_t    aluResult,
    input  wire [1:0]             irqRaise,
    output cpuPkg::byte_t         romAddr,
    output logic [1:0]            irqAck,
    output cpuPkg::dpCtrl_t       ctrl
);
    import cpuPkg::*;

    // One pipeline of states per instruction class
    typedef enum logic [4:0] {
        stIdle,
        stThread0,
        stThread1,
        stThread2,
        stDecode,
        stLoadA,
        stLoadB,
        stLoad0,
        stLoad1,
        stLoad2,
        stStoreA,
        stStoreB,
        stStore0,
        stMathsA,
        stMathsB,
        stMaths0,
        stBranch,
        stBranch0,
        stBranch1,
        stGoto,
        stGoto0,
        stGoto1,
        stGotoIdle
    } seqState_t;

    seqState_t state;
    seqState_t nextState;

    // Program counter plus offset into the current instruction
    byte_t      pc;
    byte_t      nextPc;
    logic [1:0] pcOffset;
    logic [1:0] nextOffset;

    // Load target, 0 for A and 1 for B
    logic regSel;
    logic nextRegSel;

    // Compare outcome held until the target byte is on the ROM
    logic branchTaken;
    logic nextTaken;

    logic [1:0] nextIrqAck;

    assign romAddr = pc + byte_t'(pcOffset);

    ////////////////////////////////////////////////////////////
    // State registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state       <= stIdle;
            pc          <= '0;
            pcOffset    <= 2'd0;
            regSel      <= 1'b0;
            branchTaken <= 1'b0;
            irqAck      <= 2'b00;
        end else begin
            state       <= nextState;
            pc          <= nextPc;
            pcOffset    <= nextOffset;
            regSel      <= nextRegSel;
            branchTaken <= nextTaken;
            irqAck      <= nextIrqAck;
        end
    end

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Hold by default, offset falls back to the opcode byte
        nextState  = state;
        nextPc     = pc;
        nextOffset = 2'd0;
        nextRegSel = regSel;
        nextTaken  = branchTaken;
        nextIrqAck = 2'b00;

        case (state)
            // Wait for a wake-up, line 0 wins
            stIdle: begin
                if (irqRaise[0]) begin
                    nextState  = stThread0;
                    nextPc     = vecIrq0;
                    nextIrqAck = 2'b01;
                end else if (irqRaise[1]) begin
                    nextState  = stThread0;
                    nextPc     = vecIrq1;
                    nextIrqAck = 2'b10;
                end
            end

            stThread0: nextState = stThread1;

            // Vector byte is on the ROM now
            stThread1: begin
                nextPc    = romData.addr;
                nextState = stThread2;
            end

            stThread2: nextState = stDecode;

            // Two-byte classes point the offset at their operand
            stDecode: begin
                case (romData.instr.opClass)
                    loadA: begin
                        nextState  = stLoadA;
                        nextOffset = 2'd1;
                    end
                    loadB: begin
                        nextState  = stLoadB;
                        nextOffset = 2'd1;
                    end
                    storeA: begin
                        nextState  = stStoreA;
                        nextOffset = 2'd1;
                    end
                    storeB: begin
                        nextState  = stStoreB;
                        nextOffset = 2'd1;
                    end
                    mathsA:   nextState = stMathsA;
                    mathsB:   nextState = stMathsB;
                    branch:   nextState = stBranch;
                    gotoAddr: begin
                        nextState  = stGoto;
                        nextOffset = 2'd1;
                    end
                    gotoIdle: nextState = stGotoIdle;
                    // Unknown opcode stalls here
                    default:  nextState = stDecode;
                endcase
            end

            ////////////////////////////////////////////////////////////
            // Load, address issued now, data back three cycles on
            stLoadA: begin
                nextRegSel = 1'b0;
                nextState  = stLoad0;
            end
            stLoadB: begin
                nextRegSel = 1'b1;
                nextState  = stLoad0;
            end
            stLoad0: begin
                nextPc    = pc + 8'd2;
                nextState = stLoad1;
            end
            stLoad1: nextState = stLoad2;
            stLoad2: nextState = stDecode;

            ////////////////////////////////////////////////////////////
            // Store, write strobe goes out the cycle after
            stStoreA, stStoreB: begin
                nextPc    = pc + 8'd2;
                nextState = stStore0;
            end
            stStore0: nextState = stDecode;

            ////////////////////////////////////////////////////////////
            // Maths, result saved this cycle
            stMathsA, stMathsB: begin
                nextPc    = pc + 8'd1;
                nextState = stMaths0;
            end
            stMaths0: nextState = stDecode;

            ////////////////////////////////////////////////////////////
            // Branch, compare opcode still on the ROM
            stBranch: begin
                nextTaken  = (aluResult == 8'd1);
                nextOffset = 2'd1;
                nextState  = stBranch0;
            end
            // Target byte now visible
            stBranch0: begin
                if (branchTaken) begin
                    nextPc    = romData.addr;
                    nextState = stBranch1;
                end else begin
                    // Skip the target byte
                    nextPc    = pc + 8'd2;
                    nextState = stDecode;
                end
            end
            stBranch1: nextState = stDecode;

            ////////////////////////////////////////////////////////////
            // Goto, keep pointing at the operand one more cycle
            stGoto: begin
                nextOffset = 2'd1;
                nextState  = stGoto0;
            end
            stGoto0: begin
                nextPc    = romData.addr;
                nextState = stGoto1;
            end
            stGoto1: nextState = stDecode;

            stGotoIdle: nextState = stIdle;

            default: nextState = stIdle;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Datapath control, decoded from state
    ////////////////////////////////////////////////////////////

    always_comb begin
        ctrl               = '0;
        ctrl.loadAFromBus  = (state == stLoad2) && !regSel;
        ctrl.loadBFromBus  = (state == stLoad2) && regSel;
        ctrl.loadAFromAlu  = (state == stMathsA);
        ctrl.loadBFromAlu  = (state == stMathsB);
        ctrl.latchReadAddr = (state == stLoadA) || (state == stLoadB);
        ctrl.latchWrite    = (state == stStoreA) || (state == stStoreB);
        ctrl.writeFromB    = (state == stStoreB);
    end

endmodule

`default_nettype wire

/* hw/cpuDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath (
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire cpuPkg::romWord_t romData,
    input  wire cpuPkg::byte_t    busRdData,
    input  wire cpuPkg::dpCtrl_t  ctrl,
    output cpuPkg::byte_t         aluResult,
    output cpuPkg::busReq_t       busReq
);
    import cpuPkg::*;

    // Working registers
    byte_t regA;
    byte_t regB;

    // Registered bus request fields
    byte_t busAddr;
    byte_t busWrData;
    logic  busWe;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    // Opcode nibble taken straight off the ROM word
    cpuAlu cpuAluInst (
        .regA      (regA),
        .regB      (regB),
        .aluOp     (romData.instr.aluOp),
        .aluResult (aluResult)
    );

    ////////////////////////////////////////////////////////////
    // Registers A and B
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA <= '0;
            regB <= '0;
        end else begin
            // Bus data lands at the end of a load
            if (ctrl.loadAFromBus) begin
                regA <= busRdData;
            end else if (ctrl.loadAFromAlu) begin
                regA <= aluResult;
            end

            if (ctrl.loadBFromBus) begin
                regB <= busRdData;
            end else if (ctrl.loadBFromAlu) begin
                regB <= aluResult;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Bus request
    ////////////////////////////////////////////////////////////

    // Address comes from the operand byte of a load or store
    // Otherwise the bus parks on the idle address
    always_ff @(posedge CLK) begin
        if (RESET) begin
            busAddr <= busIdleAddr;
            busWe   <= 1'b0;
        end else begin
            if (ctrl.latchReadAddr || ctrl.latchWrite) begin
                busAddr <= romData.addr;
            end else begin
                busAddr <= busIdleAddr;
            end
            // Single-cycle write strobe
            busWe <= ctrl.latchWrite;
        end
    end

    // Store data, sampled with the write strobe
    always_ff @(posedge CLK) begin
        if (ctrl.latchWrite) begin
            busWrData <= ctrl.writeFromB ? regB : regA;
        end
    end

    always_comb begin
        busReq.addr   = busAddr;
        busReq.wrData = busWrData;
        busReq.we     = busWe;
    end

endmodule

`default_nettype wire

/* hw/cpuAlu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuAlu (
    input  wire cpuPkg::byte_t  regA,
    input  wire cpuPkg::byte_t  regB,
    input  wire cpuPkg::aluOp_t aluOp,
    output cpuPkg::byte_t       aluResult
);
    import cpuPkg::*;

    // Compare flags before widening to a byte
    logic eqFlag;
    logic gtFlag;
    logic ltFlag;

    assign eqFlag = (regA == regB);
    assign gtFlag = (regA > regB);
    assign ltFlag = (regA < regB);

    always_comb begin
        case (aluOp)
            add:         aluResult = regA + regB;
            sub:         aluResult = regA - regB;
            // Low byte of the product
            mul:         aluResult = regA * regB;
            shiftLeftA:  aluResult = regA << 1;
            shiftRightA: aluResult = regA >> 1;
            incA:        aluResult = regA + 8'd1;
            incB:        aluResult = regB + 8'd1;
            decA:        aluResult = regA - 8'd1;
            decB:        aluResult = regB - 8'd1;
            // Branch conditions that the sequencer tests for exactly 1
            cmpEq:       aluResult = {{(dataWidth-1){1'b0}}, eqFlag};
            cmpGt:       aluResult = {{(dataWidth-1){1'b0}}, gtFlag};
            cmpLt:       aluResult = {{(dataWidth-1){1'b0}}, ltFlag};
            // Unused codes pass A through
            default:     aluResult = regA;
        endcase
    end

endmodule

`default_nettype wire

/* hw/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    ////////////////////////////////////////////////////////////
    // Widths and fixed addresses
    ////////////////////////////////////////////////////////////

    // Data and address share one width
    localparam int dataWidth = 8;

    typedef logic [dataWidth-1:0] byte_t;

    // ROM slots holding the thread start address per irq line
    localparam byte_t vecIrq0 = 8'hFF;
    localparam byte_t vecIrq1 = 8'hFE;

    // Address parked on the bus between accesses
    localparam byte_t busIdleAddr = 8'hFF;

    ////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////

    // Low nibble of an opcode byte
    typedef enum logic [3:0] {
        loadA    = 4'h0,
        loadB    = 4'h1,
        storeA   = 4'h2,
        storeB   = 4'h3,
        mathsA   = 4'h4,
        mathsB   = 4'h5,
        branch   = 4'h6,
        gotoAddr = 4'h7,
        gotoIdle = 4'h8
    } opClass_t;

    // High nibble, the ALU function
    // Compares give 1 when true, 0 otherwise
    typedef enum logic [3:0] {
        add         = 4'h0,
        sub         = 4'h1,
        mul         = 4'h2,
        shiftLeftA  = 4'h3,
        shiftRightA = 4'h4,
        incA        = 4'h5,
        incB        = 4'h6,
        decA        = 4'h7,
        decB        = 4'h8,
        cmpEq       = 4'h9,
        cmpGt       = 4'hA,
        cmpLt       = 4'hB
    } aluOp_t;

    typedef struct packed {
        aluOp_t   aluOp;
        opClass_t opClass;
    } instr_t;

    // One ROM byte, read either as an opcode or as an operand address
    typedef union packed {
        instr_t instr;
        byte_t  addr;
    } romWord_t;

    ////////////////////////////////////////////////////////////
    // Bus request and datapath control
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        byte_t addr;
        byte_t wrData;
        logic  we;
    } busReq_t;

    typedef struct packed {
        logic loadAFromBus;
        logic loadBFromBus;
        logic loadAFromAlu;
        logic loadBFromAlu;
        logic latchReadAddr;
        logic latchWrite;
        logic writeFromB;
    } dpCtrl_t;

endpackage

`default_nettype wire
